// File: files.f
source/queue_params_pkg.sv
source/queue_types_pkg.sv
source/lane_packer.sv
source/multi_fifo.sv
source/credit_ledger.sv
source/drain_fsm.sv
source/lane_queue_top.sv
verif/tb_clock_gen.sv
verif/lane_queue_assertions.sv
verif/lane_queue_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the lane queue testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module lane_queue_tb -o lane_queue_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/lane_queue_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q '^Simulation completed successfully$'; then
  exit 0
fi
echo "pass message not found"
exit 1

// File: source/credit_ledger.sv
/*
 * credit ledger
 * tracks the downstream credit balance and returns upstream credits,
 * one per entry popped or cleared, at most LANES per cycle
 */
`timescale 1ns/1ps

module credit_ledger (
  input  logic                       clk,
  input  logic                       rst_n,
  input  queue_types_pkg::lane_cnt_t dn_credit,
  input  queue_types_pkg::lane_cnt_t pop_cnt,
  input  logic                       clear,
  input  queue_types_pkg::occ_t      cleared_cnt,
  output queue_types_pkg::credit_t   balance,
  output queue_types_pkg::lane_cnt_t up_credit_return
);

  queue_types_pkg::occ_t pending;   // credits owed but not yet returned
  queue_types_pkg::occ_t ret_total; // owed after this edge
  queue_types_pkg::occ_t ret_now;   // returned at this edge

  // outstanding upstream credits never exceed DEPTH, so occ_t is wide enough
  assign ret_total = pending + (clear ? cleared_cnt : queue_types_pkg::occ_t'(pop_cnt));

  assign ret_now = (ret_total > queue_types_pkg::occ_t'(queue_params_pkg::LANES)) ?
                   queue_types_pkg::occ_t'(queue_params_pkg::LANES) : ret_total;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      balance          <= '0;
      pending          <= '0;
      up_credit_return <= '0;
    end else begin
      // grants in, drained entries out
      balance          <= balance
                        + queue_types_pkg::credit_t'(dn_credit)
                        - queue_types_pkg::credit_t'(pop_cnt);
      pending          <= ret_total - ret_now;
      up_credit_return <= queue_types_pkg::lane_cnt_t'(ret_now);
    end
  end

endmodule

// File: source/drain_fsm.sv
/*
 * drain FSM
 * picks how many head entries leave each cycle from occupancy and the
 * downstream balance, and runs a one-cycle FLUSH that clears the FIFO
 */
`timescale 1ns/1ps

module drain_fsm (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           flush,
  input  queue_types_pkg::occ_t          occupancy,
  input  queue_types_pkg::credit_t       balance,
  input  queue_types_pkg::entry_t [queue_params_pkg::LANES-1:0] head_data,
  output queue_types_pkg::lane_cnt_t     pop_cnt,
  output logic                           clear,
  output queue_types_pkg::drain_bundle_t dn_out
);

  queue_types_pkg::drain_state_t state_q;   // registered
  queue_types_pkg::drain_state_t state;     // live state for this cycle
  queue_types_pkg::drain_state_t state_nxt;
  queue_types_pkg::occ_t         limit;

  // FLUSH is held for exactly one cycle, otherwise the
  // registered queue status decides
  always_comb begin
    if (state_q == queue_types_pkg::FLUSH) begin
      state = queue_types_pkg::FLUSH;
    end else if (occupancy == '0) begin
      state = queue_types_pkg::IDLE;
    end else if (balance == '0) begin
      state = queue_types_pkg::STALL; // entries wait for credit
    end else begin
      state = queue_types_pkg::DRAIN;
    end
  end

  always_comb begin
    if (flush) begin
      state_nxt = queue_types_pkg::FLUSH;
    end else if (state == queue_types_pkg::FLUSH) begin
      state_nxt = queue_types_pkg::IDLE; // fifo is empty after the clear
    end else begin
      state_nxt = state;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= queue_types_pkg::IDLE;
    end else begin
      state_q <= state_nxt;
    end
  end

  // min of occupancy, balance and LANES
  always_comb begin
    limit = occupancy;
    if (queue_types_pkg::occ_t'(balance) < limit) begin
      limit = queue_types_pkg::occ_t'(balance);
    end
    if (limit > queue_types_pkg::occ_t'(queue_params_pkg::LANES)) begin
      limit = queue_types_pkg::occ_t'(queue_params_pkg::LANES);
    end
  end

  assign pop_cnt = (state == queue_types_pkg::DRAIN) ?
                   queue_types_pkg::lane_cnt_t'(limit) : '0;
  assign clear   = (state == queue_types_pkg::FLUSH);

  assign dn_out.cnt  = pop_cnt;
  assign dn_out.data = head_data; // valid below cnt only

endmodule

// File: source/lane_packer.sv
/*
 * lane packer
 * compacts a sparse push mask into contiguous low lanes, keeping lane order,
 * and counts how many lanes carry an entry
 */
`timescale 1ns/1ps

module lane_packer (
  input  queue_types_pkg::lane_bundle_t sparse,
  output queue_types_pkg::lane_bundle_t packed_lanes,
  output queue_types_pkg::lane_cnt_t    push_cnt
);

  queue_types_pkg::lane_cnt_t fill; // next free output lane

  always_comb begin
    packed_lanes = '0;
    fill         = '0;
    for (int i = 0; i < queue_params_pkg::LANES; i++) begin
      if (sparse.mask[i]) begin
        // fill stays below LANES while a set lane is left to place
        packed_lanes.mask[fill[queue_params_pkg::CNT_W-2:0]] = 1'b1;
        packed_lanes.data[fill[queue_params_pkg::CNT_W-2:0]] = sparse.data[i];
        fill = fill + 1'b1;
      end
    end
  end

  assign push_cnt = fill; // number of set lanes

endmodule

// File: source/lane_queue_top.sv
/*
 * multi-lane staging queue
 * sparse upstream pushes are packed, stored in a multi-entry FIFO and
 * drained up to LANES per cycle against downstream credit; upstream gets
 * one credit back per entry drained or flushed
 */
`timescale 1ns/1ps

module lane_queue_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  queue_types_pkg::lane_bundle_t  up_push,
  output queue_types_pkg::lane_cnt_t     up_credit_return,
  input  queue_types_pkg::lane_cnt_t     dn_credit,
  output queue_types_pkg::drain_bundle_t dn_out,
  input  logic                           flush
);

  queue_types_pkg::lane_bundle_t packed_lanes;
  queue_types_pkg::lane_cnt_t    push_cnt;
  queue_types_pkg::lane_cnt_t    pop_cnt;
  logic                          clear;
  queue_types_pkg::occ_t         occupancy;
  queue_types_pkg::occ_t         cleared_cnt;
  queue_types_pkg::credit_t      balance;

  queue_types_pkg::entry_t [queue_params_pkg::LANES-1:0] head_data;

  lane_packer i_lane_packer (
    .sparse       (up_push),
    .packed_lanes (packed_lanes),
    .push_cnt     (push_cnt)
  );

  multi_fifo i_multi_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .packed_lanes (packed_lanes),
    .push_cnt     (push_cnt),
    .pop_cnt      (pop_cnt),
    .clear        (clear),
    .head_data    (head_data),
    .occupancy    (occupancy),
    .cleared_cnt  (cleared_cnt)
  );

  credit_ledger i_credit_ledger (
    .clk              (clk),
    .rst_n            (rst_n),
    .dn_credit        (dn_credit),
    .pop_cnt          (pop_cnt),
    .clear            (clear),
    .cleared_cnt      (cleared_cnt),
    .balance          (balance),
    .up_credit_return (up_credit_return)
  );

  drain_fsm i_drain_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .occupancy (occupancy),
    .balance   (balance),
    .head_data (head_data),
    .pop_cnt   (pop_cnt),
    .clear     (clear),
    .dn_out    (dn_out)
  );

endmodule

// File: source/multi_fifo.sv
/*
 * multi-entry FIFO
 * circular buffer taking up to LANES pushes and LANES pops per edge,
 * pushes always arrive on the lowest lanes; the LANES oldest entries are
 * presented combinationally, clear discards everything and reports how much
 */
`timescale 1ns/1ps

module multi_fifo (
  input  logic                          clk,
  input  logic                          rst_n,
  input  queue_types_pkg::lane_bundle_t packed_lanes,
  input  queue_types_pkg::lane_cnt_t    push_cnt,
  input  queue_types_pkg::lane_cnt_t    pop_cnt,
  input  logic                          clear,
  output queue_types_pkg::entry_t [queue_params_pkg::LANES-1:0] head_data,
  output queue_types_pkg::occ_t         occupancy,
  output queue_types_pkg::occ_t         cleared_cnt
);

  queue_types_pkg::entry_t mem [queue_params_pkg::DEPTH];

  queue_types_pkg::ptr_t wptr;
  queue_types_pkg::ptr_t rptr;
  queue_types_pkg::ptr_t next_wptr;
  queue_types_pkg::ptr_t next_rptr;
  queue_types_pkg::occ_t next_occupancy;

  // per-lane slot addresses, wrap comes for free since DEPTH is a power of two
  queue_types_pkg::ptr_t [queue_params_pkg::LANES-1:0] wr_slot;
  queue_types_pkg::ptr_t [queue_params_pkg::LANES-1:0] rd_slot;

  always_comb begin
    for (int i = 0; i < queue_params_pkg::LANES; i++) begin
      wr_slot[i] = wptr + queue_types_pkg::ptr_t'(i);
      rd_slot[i] = rptr + queue_types_pkg::ptr_t'(i);
    end
  end

  // pointer and count arithmetic
  assign next_wptr = wptr + queue_types_pkg::ptr_t'(push_cnt);
  assign next_rptr = rptr + queue_types_pkg::ptr_t'(pop_cnt);

  assign next_occupancy = occupancy
                        + queue_types_pkg::occ_t'(push_cnt)
                        - queue_types_pkg::occ_t'(pop_cnt);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wptr      <= '0;
      rptr      <= '0;
      occupancy <= '0;
    end else if (clear) begin
      // everything held is discarded
      wptr      <= '0;
      rptr      <= '0;
      occupancy <= '0;
    end else begin
      wptr      <= next_wptr;
      rptr      <= next_rptr;
      occupancy <= next_occupancy;
    end
  end

  // storage, lanes below push_cnt are written in order from wptr
  always_ff @(posedge clk) begin
    if (!clear) begin
      for (int i = 0; i < queue_params_pkg::LANES; i++) begin
        if (queue_types_pkg::lane_cnt_t'(i) < push_cnt) begin
          mem[wr_slot[i]] <= packed_lanes.data[i];
        end
      end
    end
  end

  // oldest entries first, lanes past occupancy hold stale data
  always_comb begin
    for (int i = 0; i < queue_params_pkg::LANES; i++) begin
      head_data[i] = mem[rd_slot[i]];
    end
  end

  assign cleared_cnt = clear ? occupancy : '0; // entries thrown away this edge

endmodule

// File: source/queue_params_pkg.sv
/*
 * lane queue parameters
 * sizes shared by the packer, the FIFO, the credit ledger and the drain FSM
 */
package queue_params_pkg;

  localparam int LANES      = 4;               // lanes on each side
  localparam int DEPTH      = 16;              // FIFO entries, power of two
  localparam int DEPTH_BITS = $clog2(DEPTH);   // pointer width
  localparam int DATA_W     = 16;              // entry width

  // counts from 0 to LANES need one bit more than the lane index
  localparam int CNT_W = $clog2(LANES + 1);

  // downstream balance never goes above this
  localparam int DN_CREDIT_MAX = 8;
  localparam int CREDIT_W      = $clog2(DN_CREDIT_MAX + 1);

  // upstream starts with one credit per FIFO entry
  localparam int UP_CREDIT_INIT = DEPTH;

endpackage

// File: source/queue_types_pkg.sv
/*
 * lane queue types
 * width typedefs, the lane bundles on both sides and the drain state encoding
 */
package queue_types_pkg;

  typedef logic [queue_params_pkg::DATA_W-1:0]     entry_t;
  typedef logic [queue_params_pkg::DEPTH_BITS-1:0] ptr_t;
  typedef logic [queue_params_pkg::DEPTH_BITS:0]   occ_t;      // 0 .. DEPTH
  typedef logic [queue_params_pkg::CNT_W-1:0]      lane_cnt_t; // 0 .. LANES
  typedef logic [queue_params_pkg::CREDIT_W-1:0]   credit_t;   // 0 .. DN_CREDIT_MAX

  // push side, mask bit i qualifies data[i]
  typedef struct packed {
    logic   [queue_params_pkg::LANES-1:0] mask;
    entry_t [queue_params_pkg::LANES-1:0] data;
  } lane_bundle_t;

  // drain side, lanes below cnt are valid and data[0] is the oldest
  typedef struct packed {
    lane_cnt_t                            cnt;
    entry_t [queue_params_pkg::LANES-1:0] data;
  } drain_bundle_t;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    DRAIN = 2'd1,
    STALL = 2'd2,
    FLUSH = 2'd3
  } drain_state_t;

endpackage

// File: verif/lane_queue_assertions.sv
/*
 * lane queue protocol checks
 * upstream credit contract, no push around a flush, downstream balance
 * limit and no FIFO overflow
 */
`timescale 1ns/1ps

module lane_queue_assertions (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       flush,
  input logic                       clear,
  input queue_types_pkg::lane_cnt_t push_cnt,
  input queue_types_pkg::lane_cnt_t pop_cnt,
  input queue_types_pkg::lane_cnt_t up_credit_return,
  input queue_types_pkg::occ_t      occupancy,
  input queue_types_pkg::credit_t   balance
);

  queue_types_pkg::occ_t held; // credits upstream held before this cycle's return

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      held <= queue_types_pkg::occ_t'(queue_params_pkg::UP_CREDIT_INIT);
    end else begin
      held <= held - queue_types_pkg::occ_t'(push_cnt)
                   + queue_types_pkg::occ_t'(up_credit_return);
    end
  end

  // credits shown on up_credit_return may be spent in the same cycle
  a_push_within_credit: assert property (@(posedge clk) disable iff (!rst_n)
    queue_types_pkg::occ_t'(push_cnt) <= held + queue_types_pkg::occ_t'(up_credit_return))
    else $error("push of %0d lanes with only %0d credits held", push_cnt,
                held + queue_types_pkg::occ_t'(up_credit_return));

  a_no_push_on_flush: assert property (@(posedge clk) disable iff (!rst_n)
    (flush || clear) |-> (push_cnt == '0))
    else $error("push of %0d lanes during a flush", push_cnt);

  a_balance_limit: assert property (@(posedge clk) disable iff (!rst_n)
    balance <= queue_types_pkg::credit_t'(queue_params_pkg::DN_CREDIT_MAX))
    else $error("downstream balance %0d above its limit", balance);

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    int'(occupancy) + int'(push_cnt) - int'(pop_cnt) <= queue_params_pkg::DEPTH)
    else $error("push of %0d lanes overflows a FIFO holding %0d", push_cnt, occupancy);

endmodule

bind lane_queue_top lane_queue_assertions i_lane_queue_assertions (
  .clk              (clk),
  .rst_n            (rst_n),
  .flush            (flush),
  .clear            (clear),
  .push_cnt         (push_cnt),
  .pop_cnt          (pop_cnt),
  .up_credit_return (up_credit_return),
  .occupancy        (occupancy),
  .balance          (balance)
);

// File: verif/lane_queue_tb.sv
/*
 * lane queue testbench
 * random sparse pushes, downstream grants and flushes from a fixed seed,
 * checked cycle by cycle against a reference queue with a balance mirror
 */
`timescale 1ns/1ps

module lane_queue_tb;

  localparam int PHASE_TRAFFIC  = 800;
  localparam int HOLD_LEN       = 150; // grants held at zero
  localparam int RESUME_LEN     = 50;
  localparam int PHASE_FLUSH    = 1000;
  localparam int RUN_CYCLES     = PHASE_TRAFFIC + HOLD_LEN + RESUME_LEN + PHASE_FLUSH;
  localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 4;
  // pending returns leave at most LANES per cycle
  localparam int RETURN_TAIL    = queue_params_pkg::DEPTH / queue_params_pkg::LANES + 2;

  logic                           clk;
  logic                           rst_n;
  queue_types_pkg::lane_bundle_t  up_push;
  queue_types_pkg::lane_cnt_t     up_credit_return;
  queue_types_pkg::lane_cnt_t     dn_credit;
  queue_types_pkg::drain_bundle_t dn_out;
  logic                           flush;

  // reference model state, as it stands after the last edge
  queue_types_pkg::entry_t model_q[$];
  int model_bal      = 0;
  bit flush_q        = 1'b0; // flush sampled at the last edge
  int up_credits     = queue_params_pkg::UP_CREDIT_INIT;
  int drained_total  = 0;
  int flushed_total  = 0;
  int returned_total = 0;
  int flushes_done   = 0;

  integer seed        = 32'h97ac;
  int     error_count = 0;
  int     checks_run  = 0;
  int     cycle_count = 0;

  tb_clock_gen i_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  lane_queue_top i_lane_queue_top (
    .clk              (clk),
    .rst_n            (rst_n),
    .up_push          (up_push),
    .up_credit_return (up_credit_return),
    .dn_credit        (dn_credit),
    .dn_out           (dn_out),
    .flush            (flush)
  );

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  task automatic check_entry(input string name, input queue_types_pkg::entry_t got,
                             input queue_types_pkg::entry_t exp);
    checks_run++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input queue_types_pkg::lane_cnt_t got,
                             input queue_types_pkg::lane_cnt_t exp);
    checks_run++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_credit(input string name, input queue_types_pkg::credit_t got,
                              input queue_types_pkg::credit_t exp);
    checks_run++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_total(input string name, input int got, input int exp);
    checks_run++;
    if (got != exp) begin
      error_count++;
      $display("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, error_count - errors_before);
    end
  endtask

  // drain count expected from the registered model state
  function automatic int expected_drain();
    int n;
    n = model_q.size();
    if (flush_q) n = 0; // FLUSH cycle drains nothing
    if (model_bal < n) n = model_bal;
    if (n > queue_params_pkg::LANES) n = queue_params_pkg::LANES;
    return n;
  endfunction

  // one cycle: sample and check at the falling edge, drive, then advance the model
  task automatic run_cycle(input bit allow_push, input bit allow_grant, input bit allow_flush);
    queue_types_pkg::drain_bundle_t seen;
    logic [queue_params_pkg::LANES-1:0] mask;
    queue_types_pkg::entry_t [queue_params_pkg::LANES-1:0] data;
    int  exp_cnt;
    int  room;
    int  grant;
    int  lanes_set;
    bit  do_flush;
    @(negedge clk);
    seen           = dn_out;
    returned_total = returned_total + int'(up_credit_return);
    up_credits     = up_credits + int'(up_credit_return);
    exp_cnt        = expected_drain();
    check_count("dn_out.cnt", seen.cnt, queue_types_pkg::lane_cnt_t'(exp_cnt));
    for (int i = 0; i < exp_cnt; i++) begin
      check_entry($sformatf("dn_out.data[%0d]", i), seen.data[i], model_q[i]);
    end
    check_credit("balance", i_lane_queue_top.balance,
                 queue_types_pkg::credit_t'(model_bal));

    do_flush  = allow_flush && (rand_below(40) == 0);
    mask      = '0;
    lanes_set = 0;
    for (int i = 0; i < queue_params_pkg::LANES; i++) begin
      data[i] = queue_types_pkg::entry_t'($random(seed));
      if (allow_push && !do_flush && !flush_q && lanes_set < up_credits) begin
        mask[i] = (rand_below(2) == 1); // sparse lanes
      end
      if (mask[i]) lanes_set++;
    end
    room = queue_params_pkg::DN_CREDIT_MAX - model_bal + exp_cnt;
    if (room > queue_params_pkg::LANES) room = queue_params_pkg::LANES;
    grant = allow_grant ? rand_below(room + 1) : 0;

    up_push.mask = mask;
    up_push.data = data;
    dn_credit    = queue_types_pkg::lane_cnt_t'(grant);
    flush        = do_flush;

    for (int i = 0; i < exp_cnt; i++) begin
      void'(model_q.pop_front());
    end
    drained_total = drained_total + exp_cnt;
    model_bal     = model_bal + grant - exp_cnt;
    if (flush_q) begin // clear discards what is held
      flushed_total = flushed_total + model_q.size();
      flushes_done++;
      model_q.delete();
    end
    for (int i = 0; i < queue_params_pkg::LANES; i++) begin
      if (mask[i]) begin
        model_q.push_back(data[i]); // compacted in lane order
        up_credits--;
      end
    end
    flush_q = do_flush;
  endtask

  initial begin
    int mark;
    up_push   = '0;
    dn_credit = '0;
    flush     = 1'b0;

    mark = error_count;
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_count("dn_out.cnt", dn_out.cnt, '0);
    check_count("up_credit_return", up_credit_return, '0);
    check_credit("balance", i_lane_queue_top.balance, '0);
    report_test("reset_values", mark);

    mark = error_count;
    repeat (PHASE_TRAFFIC) run_cycle(1'b1, 1'b1, 1'b0);
    report_test("packed_order", mark);

    mark = error_count;
    repeat (HOLD_LEN) run_cycle(1'b1, 1'b0, 1'b0);
    if (model_q.size() == 0) begin
      error_count++;
      $display("the zero-grant hold ended with an empty queue, so nothing was stalled");
    end
    repeat (RESUME_LEN) run_cycle(1'b1, 1'b1, 1'b0);
    report_test("back_pressure", mark);

    mark = error_count;
    flushes_done = 0;
    repeat (PHASE_FLUSH) run_cycle(1'b1, 1'b1, 1'b1);
    if (flushes_done == 0) begin
      error_count++;
      $display("no flush was issued during the flush phase");
    end
    report_test("flush_recovery", mark);

    // let the queue run dry, then give the pending returns time to come back
    mark = error_count;
    while (model_q.size() != 0 || flush_q) begin
      run_cycle(1'b0, 1'b1, 1'b0);
    end
    repeat (RETURN_TAIL) run_cycle(1'b0, 1'b1, 1'b0);
    check_total("up_credit_return total", returned_total, drained_total + flushed_total);
    check_total("upstream credits held", up_credits, queue_params_pkg::UP_CREDIT_INIT);
    report_test("credit_totals", mark);

    $display("%0d checks, %0d errors, %0d drained, %0d flushed",
             checks_run, error_count, drained_total, flushed_total);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verif/tb_clock_gen.sv
/*
 * testbench clock and reset
 * free-running 8 ns clock, active-low reset held for 5 cycles
 * and released on a falling edge
 */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int PERIOD_NS    = 8;
  localparam int RESET_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk); // release away from the active edge
    rst_n = 1'b1;
  end

endmodule
